//--- fas_fir_coef.svh
`ifndef FAS_FIR_COEF_SVH
`define FAS_FIR_COEF_SVH

`default_nettype none

// symmetric low-pass, coefficient k weights taps k and 31-k
// k = 15 is the center pair, k = 0 the outermost pair
// dc gain is about 1.22 after the 16-bit shift, so a large dc input saturates

`define FIR_C00 (-16'sd70)
`define FIR_C01 (-16'sd110)
`define FIR_C02 (-16'sd136)
`define FIR_C03 (-16'sd116)
`define FIR_C04 (16'sd0)
`define FIR_C05 (16'sd238)
`define FIR_C06 (16'sd580)
`define FIR_C07 (16'sd957)
`define FIR_C08 (16'sd1334)
`define FIR_C09 (16'sd1798)
`define FIR_C10 (16'sd2610)
`define FIR_C11 (16'sd3770)
`define FIR_C12 (16'sd5162)
`define FIR_C13 (16'sd6670)
`define FIR_C14 (16'sd8120)
`define FIR_C15 (16'sd9135)

`default_nettype wire

`endif

//--- fas_pkg.sv
`include "fas_fir_coef.svh"
`default_nettype none

package fas_pkg;

    localparam int SAMPLE_W   = 16;
    localparam int NUM_TAPS   = 32;
    localparam int FRAME_LEN  = 16;
    localparam int ACC_W      = 40;
    localparam int FIR_SHIFT  = 16;
    // wide working width for rounding and saturation
    localparam int WIDE_W     = 48;
    // each radix-4 butterfly scales its outputs by 1/4
    localparam int BFLY_SHIFT = 2;
    localparam int TW_LEN     = 10;
    localparam int SAMPLE_MAX = 2 ** (SAMPLE_W - 1) - 1;
    localparam int SAMPLE_MIN = -(2 ** (SAMPLE_W - 1));

    typedef logic signed [SAMPLE_W-1:0] sample_t;

    typedef struct packed {
        sample_t re;
        sample_t im;
    } cplx_t;

    // index 0 is the oldest sample
    typedef sample_t [FRAME_LEN-1:0] frame_t;
    typedef cplx_t [FRAME_LEN-1:0] bins_t;

    localparam sample_t FIR_COEF [0:NUM_TAPS/2-1] = '{
        `FIR_C00, `FIR_C01, `FIR_C02, `FIR_C03,
        `FIR_C04, `FIR_C05, `FIR_C06, `FIR_C07,
        `FIR_C08, `FIR_C09, `FIR_C10, `FIR_C11,
        `FIR_C12, `FIR_C13, `FIR_C14, `FIR_C15
    };

    // W16^m = cos(2*pi*m/16) - j*sin(2*pi*m/16) in Q1.15
    localparam sample_t TW_RE [0:TW_LEN-1] = '{
        16'sd32767, 16'sd30274, 16'sd23170, 16'sd12540, 16'sd0,
        -16'sd12540, -16'sd23170, -16'sd30274, 16'sh8000, -16'sd30274
    };
    localparam sample_t TW_IM [0:TW_LEN-1] = '{
        16'sd0, -16'sd12540, -16'sd23170, -16'sd30274, 16'sh8000,
        -16'sd30274, -16'sd23170, -16'sd12540, 16'sd0, 16'sd12540
    };

    // arithmetic right shift with round half up
    function automatic logic signed [WIDE_W-1:0] round_shift(
        input logic signed [WIDE_W-1:0] v,
        input int sh
    );
        logic signed [WIDE_W-1:0] one;
        one = 1;
        if (sh == 0) begin
            return v;
        end
        return (v + (one <<< (sh - 1))) >>> sh;
    endfunction

    function automatic sample_t saturate(input logic signed [WIDE_W-1:0] v);
        if (v > SAMPLE_MAX) begin
            return sample_t'(SAMPLE_MAX);
        end
        if (v < SAMPLE_MIN) begin
            return sample_t'(SAMPLE_MIN);
        end
        return v[SAMPLE_W-1:0];
    endfunction

endpackage

`default_nettype wire

//--- fir_filter.sv
`default_nettype none

module fir_filter (
    input  logic              clk,
    input  logic              rst,
    input  logic              sample_valid_i,
    input  fas_pkg::sample_t  sample_i,
    output logic              fir_valid_o,
    output fas_pkg::sample_t  fir_d_o
);

    localparam int NUM_TAPS = fas_pkg::NUM_TAPS;
    localparam int HALF     = NUM_TAPS / 2;
    localparam int FILL_W   = $clog2(NUM_TAPS);
    localparam logic [FILL_W-1:0] FILL_LAST = FILL_W'(NUM_TAPS - 1);

    // taps_q[0] holds the newest sample
    fas_pkg::sample_t taps_q [NUM_TAPS];
    logic [FILL_W-1:0] fill_q;

    logic signed [fas_pkg::SAMPLE_W:0]  pair;
    logic signed [fas_pkg::ACC_W-1:0]   acc;

    // symmetric pre-add then one multiply per pair
    always_comb begin
        acc  = '0;
        pair = '0;
        for (int k = 0; k < HALF; k++) begin
            pair = taps_q[k] + taps_q[NUM_TAPS-1-k];
            acc  = acc + pair * fas_pkg::FIR_COEF[k];
        end
    end

    assign fir_d_o = fas_pkg::saturate(fas_pkg::round_shift(acc, fas_pkg::FIR_SHIFT));

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_TAPS; i++) begin
                taps_q[i] <= '0;
            end
            fill_q      <= '0;
            fir_valid_o <= 1'b0;
        end else begin
            // strobe only once the whole line holds real samples
            fir_valid_o <= sample_valid_i && (fill_q == FILL_LAST);
            if (sample_valid_i) begin
                taps_q[0] <= sample_i;
                for (int i = 1; i < NUM_TAPS; i++) begin
                    taps_q[i] <= taps_q[i-1];
                end
                if (fill_q != FILL_LAST) begin
                    fill_q <= fill_q + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- frame_buffer.sv
`default_nettype none

module frame_buffer (
    input  logic              clk,
    input  logic              rst,
    input  logic              fir_valid_i,
    input  fas_pkg::sample_t  fir_d_i,
    output logic              frame_valid_o,
    output fas_pkg::frame_t   frame_o
);

    localparam int IDX_W = $clog2(fas_pkg::FRAME_LEN);
    localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(fas_pkg::FRAME_LEN - 1);

    logic [IDX_W-1:0] idx_q;
    fas_pkg::frame_t  stage_q;
    fas_pkg::frame_t  stage_nxt;

    // staging frame with the current sample already in place
    always_comb begin
        stage_nxt        = stage_q;
        stage_nxt[idx_q] = fir_d_i;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            idx_q         <= '0;
            stage_q       <= '0;
            frame_o       <= '0;
            frame_valid_o <= 1'b0;
        end else begin
            frame_valid_o <= fir_valid_i && (idx_q == IDX_LAST);
            if (fir_valid_i) begin
                stage_q[idx_q] <= fir_d_i;
                idx_q          <= idx_q + 1'b1;
                if (idx_q == IDX_LAST) begin
                    frame_o <= stage_nxt;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- butterfly4.sv
`default_nettype none

module butterfly4 (
    input  fas_pkg::cplx_t a_i,
    input  fas_pkg::cplx_t b_i,
    input  fas_pkg::cplx_t c_i,
    input  fas_pkg::cplx_t d_i,
    output fas_pkg::cplx_t y0_o,
    output fas_pkg::cplx_t y1_o,
    output fas_pkg::cplx_t y2_o,
    output fas_pkg::cplx_t y3_o
);

    localparam int SW = fas_pkg::SAMPLE_W;

    logic signed [SW:0] t0r, t0i, t1r, t1i;
    logic signed [SW:0] t2r, t2i, t3r, t3i;

    // full 18-bit sum, then one rounding step to 1/4 scale
    function automatic fas_pkg::sample_t scale(input logic signed [SW+1:0] v);
        return fas_pkg::saturate(fas_pkg::round_shift(v, fas_pkg::BFLY_SHIFT));
    endfunction

    assign t0r = a_i.re + c_i.re;
    assign t0i = a_i.im + c_i.im;
    assign t1r = a_i.re - c_i.re;
    assign t1i = a_i.im - c_i.im;
    assign t2r = b_i.re + d_i.re;
    assign t2i = b_i.im + d_i.im;
    assign t3r = b_i.re - d_i.re;
    assign t3i = b_i.im - d_i.im;

    assign y0_o.re = scale(t0r + t2r);
    assign y0_o.im = scale(t0i + t2i);
    assign y2_o.re = scale(t0r - t2r);
    assign y2_o.im = scale(t0i - t2i);

    // -j*(b-d) is a swap of re and im with the new im negated
    assign y1_o.re = scale(t1r + t3i);
    assign y1_o.im = scale(t1i - t3r);
    assign y3_o.re = scale(t1r - t3i);
    assign y3_o.im = scale(t1i + t3r);

endmodule

`default_nettype wire

//--- fft16.sv
`default_nettype none

module fft16 #(
    parameter int BIN_SHIFT = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             frame_valid_i,
    input  fas_pkg::frame_t  frame_i,
    output logic             fft_valid_o,
    output fas_pkg::bins_t   fft_bins_o
);

    localparam int RADIX     = 4;
    localparam int SW        = fas_pkg::SAMPLE_W;
    // scaling still owed after two butterfly stages
    localparam int REM_SHIFT = BIN_SHIFT - 2 * fas_pkg::BFLY_SHIFT;

    // first index is the column n, second the stage-one bin k1
    fas_pkg::cplx_t s1_in  [RADIX][RADIX];
    fas_pkg::cplx_t s1_out [RADIX][RADIX];
    fas_pkg::cplx_t s1_rot [RADIX][RADIX];
    fas_pkg::cplx_t s1_q   [RADIX][RADIX];
    // first index is k1, second k2
    fas_pkg::cplx_t s2_out [RADIX][RADIX];
    fas_pkg::bins_t bins_nxt;

    logic signed [2*SW:0] rot_re;
    logic signed [2*SW:0] rot_im;
    logic                 s1_valid_q;

    // real input, column n takes samples n, n+4, n+8, n+12
    always_comb begin
        for (int n = 0; n < RADIX; n++) begin
            for (int m = 0; m < RADIX; m++) begin
                s1_in[n][m].re = frame_i[n + RADIX*m];
                s1_in[n][m].im = '0;
            end
        end
    end

    for (genvar n = 0; n < RADIX; n++) begin : g_stage1
        butterfly4 u_bf (
            .a_i  (s1_in[n][0]),
            .b_i  (s1_in[n][1]),
            .c_i  (s1_in[n][2]),
            .d_i  (s1_in[n][3]),
            .y0_o (s1_out[n][0]),
            .y1_o (s1_out[n][1]),
            .y2_o (s1_out[n][2]),
            .y3_o (s1_out[n][3])
        );
    end

    // rotate output (n, k1) by W16^(n*k1)
    always_comb begin
        rot_re = '0;
        rot_im = '0;
        for (int n = 0; n < RADIX; n++) begin
            for (int k = 0; k < RADIX; k++) begin
                rot_re = s1_out[n][k].re * fas_pkg::TW_RE[n*k]
                       - s1_out[n][k].im * fas_pkg::TW_IM[n*k];
                rot_im = s1_out[n][k].re * fas_pkg::TW_IM[n*k]
                       + s1_out[n][k].im * fas_pkg::TW_RE[n*k];
                s1_rot[n][k].re = fas_pkg::saturate(fas_pkg::round_shift(rot_re, SW - 1));
                s1_rot[n][k].im = fas_pkg::saturate(fas_pkg::round_shift(rot_im, SW - 1));
            end
        end
    end

    for (genvar k1 = 0; k1 < RADIX; k1++) begin : g_stage2
        butterfly4 u_bf (
            .a_i  (s1_q[0][k1]),
            .b_i  (s1_q[1][k1]),
            .c_i  (s1_q[2][k1]),
            .d_i  (s1_q[3][k1]),
            .y0_o (s2_out[k1][0]),
            .y1_o (s2_out[k1][1]),
            .y2_o (s2_out[k1][2]),
            .y3_o (s2_out[k1][3])
        );
    end

    // output (k1, k2) lands in bin k1 + 4*k2
    always_comb begin
        for (int k1 = 0; k1 < RADIX; k1++) begin
            for (int k2 = 0; k2 < RADIX; k2++) begin
                bins_nxt[k1 + RADIX*k2].re =
                    fas_pkg::saturate(fas_pkg::round_shift(s2_out[k1][k2].re, REM_SHIFT));
                bins_nxt[k1 + RADIX*k2].im =
                    fas_pkg::saturate(fas_pkg::round_shift(s2_out[k1][k2].im, REM_SHIFT));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int n = 0; n < RADIX; n++) begin
                for (int k = 0; k < RADIX; k++) begin
                    s1_q[n][k] <= '0;
                end
            end
            s1_valid_q  <= 1'b0;
            fft_valid_o <= 1'b0;
            fft_bins_o  <= '0;
        end else begin
            s1_valid_q  <= frame_valid_i;
            fft_valid_o <= s1_valid_q;
            if (frame_valid_i) begin
                s1_q <= s1_rot;
            end
            if (s1_valid_q) begin
                fft_bins_o <= bins_nxt;
            end
        end
    end

endmodule

`default_nettype wire

//--- fas_top.sv
`default_nettype none

module fas_top #(
    parameter int BIN_SHIFT = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              sample_valid_i,
    input  fas_pkg::sample_t  sample_i,
    output logic              fir_valid_o,
    output fas_pkg::sample_t  fir_d_o,
    output logic              fft_valid_o,
    output fas_pkg::bins_t    fft_bins_o
);

    logic            frame_valid;
    fas_pkg::frame_t frame;

    // sample to bins is filter, framing, then the two fft stages
    fir_filter u_fir (
        .clk            (clk),
        .rst            (rst),
        .sample_valid_i (sample_valid_i),
        .sample_i       (sample_i),
        .fir_valid_o    (fir_valid_o),
        .fir_d_o        (fir_d_o)
    );

    frame_buffer u_frame (
        .clk           (clk),
        .rst           (rst),
        .fir_valid_i   (fir_valid_o),
        .fir_d_i       (fir_d_o),
        .frame_valid_o (frame_valid),
        .frame_o       (frame)
    );

    fft16 #(
        .BIN_SHIFT (BIN_SHIFT)
    ) u_fft (
        .clk           (clk),
        .rst           (rst),
        .frame_valid_i (frame_valid),
        .frame_i       (frame),
        .fft_valid_o   (fft_valid_o),
        .fft_bins_o    (fft_bins_o)
    );

endmodule

`default_nettype wire

//--- fas_checker.sv
`default_nettype none

module fas_checker (
    input  logic              clk,
    input  logic              rst,
    input  logic              sample_valid_i,
    input  fas_pkg::sample_t  sample_i,
    input  logic              fir_valid_i,
    input  fas_pkg::sample_t  fir_d_i,
    input  logic              fft_valid_i,
    input  fas_pkg::bins_t    fft_bins_i,
    input  logic [95:0]       test_name_i,
    input  logic              test_done_i,
    input  int                exp_peak_i,
    output int                pass_cnt_o,
    output int                fail_cnt_o
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam real PI = 3.14159265358979;

    int   hist [32];
    int   frame_vals [16];
    int   frame_q [$];
    int   fft_cycle_q [$];
    int   n_samples, frame_cnt, cyc, exp_fir, test_errs, test_checks, last_peak;
    logic exp_fir_valid;

    // direct form of the 32-tap rule with round half up and saturation
    function automatic int fir_model();
        longint acc;
        int c;
        acc = 0;
        for (int t = 0; t < 32; t++) begin
            c = (t < 16) ? t : 31 - t;
            acc += longint'(fas_pkg::FIR_COEF[c]) * hist[t];
        end
        acc = (acc + 32768) >>> 16;
        if (acc > 32767) acc = 32767;
        if (acc < -32768) acc = -32768;
        return int'(acc);
    endfunction

    function automatic real abs_real(input real v);
        return (v < 0.0) ? -v : v;
    endfunction

    task automatic compare_frame();
        real ex_re, ex_im, ang;
        int  x [16];
        int  mag, best;
        for (int n = 0; n < 16; n++) x[n] = frame_q.pop_front();
        best = -1;
        for (int k = 0; k < 16; k++) begin
            ex_re = 0.0;
            ex_im = 0.0;
            for (int n = 0; n < 16; n++) begin
                ang = 2.0 * PI * k * n / 16.0;
                ex_re += x[n] * $cos(ang) / 16.0;
                ex_im -= x[n] * $sin(ang) / 16.0;
            end
            test_checks++;
            if (abs_real(ex_re - fft_bins_i[k].re) > 3.0 ||
                abs_real(ex_im - fft_bins_i[k].im) > 3.0) begin
                test_errs++;
                $display("error %s bin %0d expected %0.2f %0.2f actual %0d %0d", test_name_i,
                         k, ex_re, ex_im, fft_bins_i[k].re, fft_bins_i[k].im);
            end
            mag = fft_bins_i[k].re * fft_bins_i[k].re + fft_bins_i[k].im * fft_bins_i[k].im;
            if (mag > best) begin
                best      = mag;
                last_peak = k;
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            for (int t = 0; t < 32; t++) hist[t] = 0;
            n_samples = 0;
            frame_cnt = 0;
            cyc = 0;
            exp_fir_valid = 1'b0;
            frame_q.delete();
            fft_cycle_q.delete();
            test_errs = 0;
            test_checks = 0;
            last_peak = -1;
            pass_cnt_o <= 0;
            fail_cnt_o <= 0;
        end else begin
            cyc++;
            if (fir_valid_i !== exp_fir_valid) begin
                test_errs++;
                $display("%s fir_valid_o came at the wrong cycle", test_name_i);
            end else if (fir_valid_i) begin
                test_checks++;
                if (fir_d_i != exp_fir) begin
                    test_errs++;
                    $display("error %s fir_d_o expected %0d actual %0d", test_name_i,
                             exp_fir, fir_d_i);
                end
            end
            if (fft_cycle_q.size() > 0 && fft_cycle_q[0] == cyc) begin
                void'(fft_cycle_q.pop_front());
                if (fft_valid_i) begin
                    compare_frame();
                end else begin
                    test_errs++;
                    for (int n = 0; n < 16; n++) void'(frame_q.pop_front());
                    $display("%s fft_valid_o did not come 4 cycles after the frame", test_name_i);
                end
            end else if (fft_valid_i) begin
                test_errs++;
                $display("%s fft_valid_o pulsed with no frame pending", test_name_i);
            end
            exp_fir_valid = 1'b0;
            if (sample_valid_i) begin
                for (int t = 31; t > 0; t--) hist[t] = hist[t-1];
                hist[0] = sample_i;
                n_samples++;
                if (n_samples >= 32) begin
                    exp_fir_valid = 1'b1;
                    exp_fir = fir_model();
                    frame_vals[frame_cnt] = exp_fir;
                    frame_cnt++;
                    if (frame_cnt == 16) begin
                        for (int n = 0; n < 16; n++) frame_q.push_back(frame_vals[n]);
                        fft_cycle_q.push_back(cyc + 4);
                        frame_cnt = 0;
                    end
                end
            end
            if (test_done_i) begin
                if (exp_peak_i >= 0 && last_peak != exp_peak_i) begin
                    test_errs++;
                    $display("error %s peak bin expected %0d actual %0d", test_name_i,
                             exp_peak_i, last_peak);
                end
                if (test_errs == 0) begin
                    $display("test %s passed, %0d checks", test_name_i, test_checks);
                    pass_cnt_o <= pass_cnt_o + 1;
                end else begin
                    $display("test %s failed, %0d of %0d checks wrong", test_name_i,
                             test_errs, test_checks);
                    fail_cnt_o <= fail_cnt_o + 1;
                end
                test_errs = 0;
                test_checks = 0;
                last_peak = -1;
            end
        end
    end

endmodule

`default_nettype wire

//--- fas_properties.sv
`default_nettype none

module fas_properties (
    input logic clk,
    input logic rst,
    input logic sample_valid_i,
    input logic fir_valid_i,
    input logic frame_valid_i,
    input logic fft_valid_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // failed assertions so far
    int err_cnt = 0;

    // filter output is always one cycle behind a sample
    a_fir_follows_sample: assert property (@(posedge clk) disable iff (rst)
        fir_valid_i |-> $past(sample_valid_i))
        else begin
            err_cnt++;
            $error("fir_valid_o without a sample strobe one cycle before");
        end

    a_fft_single_pulse: assert property (@(posedge clk) disable iff (rst)
        fft_valid_i |=> !fft_valid_i)
        else begin
            err_cnt++;
            $error("fft_valid_o high in two consecutive cycles");
        end

    a_quiet_in_reset: assert property (@(posedge clk)
        $past(rst) |-> !fir_valid_i && !frame_valid_i && !fft_valid_i)
        else begin
            err_cnt++;
            $error("strobe high while in reset");
        end

endmodule

bind fas_top fas_properties u_props (
    .clk            (clk),
    .rst            (rst),
    .sample_valid_i (sample_valid_i),
    .fir_valid_i    (fir_valid_o),
    .frame_valid_i  (frame_valid),
    .fft_valid_i    (fft_valid_o)
);

`default_nettype wire

//--- tb_fas_top.sv
`default_nettype none

module tb_fas_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_TESTS = 6;
    localparam int DRAIN     = 10;

    typedef enum logic [1:0] {K_ZERO, K_DC, K_IMPULSE, K_RANDOM} kind_t;

    typedef struct packed {
        logic [95:0]      name;
        kind_t            kind;
        fas_pkg::sample_t amp;
        int               count;
        int               gap;
        int               peak;
    } row_t;

    row_t             rows [NUM_TESTS];
    logic             clk, rst, sample_valid_i, fft_valid_o, fir_valid_o, test_done;
    fas_pkg::sample_t sample_i, fir_d_o;
    fas_pkg::bins_t   fft_bins_o;
    logic [95:0]      test_name;
    int               exp_peak, pass_cnt, fail_cnt, cycles, limit;
    int unsigned      lcg_state;

    fas_top #(.BIN_SHIFT(4)) DUT (
        .clk            (clk),
        .rst            (rst),
        .sample_valid_i (sample_valid_i),
        .sample_i       (sample_i),
        .fir_valid_o    (fir_valid_o),
        .fir_d_o        (fir_d_o),
        .fft_valid_o    (fft_valid_o),
        .fft_bins_o     (fft_bins_o)
    );

    fas_checker u_chk (
        .clk(clk), .rst(rst), .sample_valid_i(sample_valid_i), .sample_i(sample_i),
        .fir_valid_i(fir_valid_o), .fir_d_i(fir_d_o), .fft_valid_i(fft_valid_o),
        .fft_bins_i(fft_bins_o), .test_name_i(test_name), .test_done_i(test_done),
        .exp_peak_i(exp_peak), .pass_cnt_o(pass_cnt), .fail_cnt_o(fail_cnt)
    );

    always #5 clk = ~clk;

    function automatic int unsigned next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic run_test(input row_t r);
        fas_pkg::sample_t x;
        int g;
        for (int i = 0; i < r.count; i++) begin
            case (r.kind)
                K_DC:      x = r.amp;
                K_IMPULSE: x = (i == 0) ? r.amp : '0;
                K_RANDOM:  x = fas_pkg::sample_t'(next_random() >> 16);
                default:   x = '0;
            endcase
            @(posedge clk);
            sample_valid_i <= 1'b1;
            sample_i       <= x;
            g = (r.kind == K_RANDOM) ? int'(next_random() % (r.gap + 1)) : r.gap;
            repeat (g) begin
                @(posedge clk);
                sample_valid_i <= 1'b0;
            end
        end
        @(posedge clk);
        sample_valid_i <= 1'b0;
    endtask

    // limit from the table length plus headroom for reset and drains
    always @(posedge clk) begin
        cycles++;
        if (cycles >= limit) begin
            $display("timeout after %0d cycles, the run did not finish", cycles);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        rows[0] = '{"zero",     K_ZERO,    16'sd0,     64,  0, -1};
        rows[1] = '{"impulse",  K_IMPULSE, 16'sd32767, 48,  1, -1};
        rows[2] = '{"dc",       K_DC,      16'sd8000,  96,  0,  0};
        rows[3] = '{"random",   K_RANDOM,  16'sd0,     120, 3, -1};
        rows[4] = '{"dc_sat",   K_DC,      16'sd30000, 64,  0,  0};
        rows[5] = '{"zero_end", K_ZERO,    16'sd0,     40,  2, -1};
        limit = 200;
        for (int t = 0; t < NUM_TESTS; t++) limit += rows[t].count * (rows[t].gap + 1);
        cycles         = 0;
        lcg_state      = 32'd53625;
        clk            = 1'b0;
        rst            = 1'b1;
        sample_valid_i = 1'b0;
        sample_i       = '0;
        test_done      = 1'b0;
        test_name      = rows[0].name;
        exp_peak       = -1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            test_name <= rows[t].name;
            exp_peak  <= rows[t].peak;
            run_test(rows[t]);
            repeat (DRAIN) @(posedge clk);
            test_done <= 1'b1;
            @(posedge clk);
            test_done <= 1'b0;
        end
        @(posedge clk);
        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && pass_cnt == NUM_TESTS && DUT.u_props.err_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- fas_top.f
+incdir+.
fas_pkg.sv
fir_filter.sv
frame_buffer.sv
butterfly4.sv
fft16.sv
fas_top.sv
fas_checker.sv
fas_properties.sv
tb_fas_top.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_fas_top
FILELIST = fas_top.f
OBJ_DIR  = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Everything OK"

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
